//--- common/dense_config.svh
// width, size, fixed-point and output-gap macros for the dense layer
`ifndef DENSE_CONFIG_SVH
`define DENSE_CONFIG_SVH

// ################################################
// number format
// ################################################

// one fixed-point value, q5.10
`define DENSE_DATA_WIDTH 16

// fraction bits, also the product shift
`define DENSE_FRAC_BITS 10

// ################################################
// layer shape
// ################################################

`define DENSE_NUM_INPUTS 2
`define DENSE_NUM_OUTPUTS 4

// accumulator, wide enough for products plus bias
`define DENSE_ACC_WIDTH 40

// ################################################
// stream wrapper
// ################################################

// idle cycles after a result before new input
`define DENSE_OUTPUT_GAP 2

`endif

//--- common/dense_pkg.sv
// fixed-point, vector and fsm state types for the dense layer
`include "dense_config.svh"

package dense_pkg;

  // ################################################
  // data types
  // ################################################

  // single signed q5.10 value
  typedef logic signed [`DENSE_DATA_WIDTH-1:0] fix_t;

  // accumulator for bias plus shifted products
  typedef logic signed [`DENSE_ACC_WIDTH-1:0] acc_t;

  // input and output vectors, element 0 in the low bits
  typedef fix_t [`DENSE_NUM_INPUTS-1:0] in_vec_t;
  typedef fix_t [`DENSE_NUM_OUTPUTS-1:0] out_vec_t;

  // ################################################
  // state encodings
  // ################################################

  // core sequencer
  typedef enum logic [1:0] {
    CORE_IDLE,
    CORE_CALC,
    CORE_DONE
  } core_state_t;

  // output holding buffer
  typedef enum logic {
    HOLD_EMPTY,
    HOLD_FULL
  } hold_state_t;

  // wait after each result
  typedef enum logic {
    GAP_OPEN,
    GAP_WAIT
  } gap_state_t;

endpackage

//--- dense_core/dense_core.sv
// dense_core: sequential mac layer, start/done/idle control, fixed weight table
`timescale 1ns/100ps
`include "dense_config.svh"

module dense_core (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ap_start,
  output logic                ap_idle,
  output logic                ap_done,
  input  dense_pkg::in_vec_t  ap_in,
  output dense_pkg::out_vec_t ap_return
);

  import dense_pkg::*;

  localparam int IDX_W = $clog2(`DENSE_NUM_OUTPUTS);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`DENSE_NUM_OUTPUTS - 1);

  // ################################################
  // weight and bias table, q5.10
  // ################################################

  // row k holds the weights of output k
  localparam fix_t W_TABLE [0:`DENSE_NUM_OUTPUTS-1][0:`DENSE_NUM_INPUTS-1] = '{
    '{16'sd512, -16'sd256},
    '{16'sd1024, 16'sd768},
    '{-16'sd1536, 16'sd128},
    '{16'sd2048, -16'sd640}
  };

  // 0.25, -0.5, 1.0, 0.0625
  localparam fix_t BIAS_TABLE [0:`DENSE_NUM_OUTPUTS-1] = '{
    16'sd256,
    -16'sd512,
    16'sd1024,
    16'sd64
  };

  core_state_t      state;
  logic [IDX_W-1:0] idx;
  in_vec_t          in_q;
  fix_t             calc_result;

  assign ap_idle = (state == CORE_IDLE);
  assign ap_done = (state == CORE_DONE);

  // ################################################
  // sequencer
  // ################################################

  // idle -> one calc cycle per output -> single done cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= CORE_IDLE;
      idx   <= '0;
    end else begin
      case (state)
        CORE_IDLE: begin
          idx <= '0;
          if (ap_start)
            state <= CORE_CALC;
        end
        CORE_CALC: begin
          if (idx == LAST_IDX)
            state <= CORE_DONE;
          else
            idx <= idx + 1'b1;
        end
        CORE_DONE: state <= CORE_IDLE;
        default:   state <= CORE_IDLE;
      endcase
    end
  end

  // operands latched on start, results stored per output
  always_ff @(posedge clk) begin
    if (state == CORE_IDLE && ap_start)
      in_q <= ap_in;
    if (state == CORE_CALC)
      ap_return[idx] <= calc_result;
  end

  // ################################################
  // mac for output idx
  // ################################################

  always_comb begin
    acc_t sum;
    acc_t prod;
    sum = acc_t'(BIAS_TABLE[idx]);
    for (int i = 0; i < `DENSE_NUM_INPUTS; i++) begin
      prod = acc_t'(in_q[i]) * acc_t'(W_TABLE[idx][i]);
      // drop the extra fraction bits of the product
      sum = sum + (prod >>> `DENSE_FRAC_BITS);
    end
    // wraps to the data width
    calc_result = sum[`DENSE_DATA_WIDTH-1:0];
  end

  // bridge must only start the core while it sits idle
  a_start_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n) ap_start |-> ap_idle
  );

endmodule

//--- dv/dense_ref_model.svh
// expected layer outputs from the testbench's own weight and bias table
`ifndef DENSE_REF_MODEL_SVH
`define DENSE_REF_MODEL_SVH

// one input vector in, the full expected output vector out
function automatic out_vec_t ref_layer(input in_vec_t x);
  int       w_tab [0:`DENSE_NUM_OUTPUTS-1][0:`DENSE_NUM_INPUTS-1];
  int       b_tab [0:`DENSE_NUM_OUTPUTS-1];
  longint   sum;
  longint   prod;
  fix_t     xi;
  out_vec_t y;
  // q5.10 weights, row k feeds output k
  w_tab = '{'{512, -256}, '{1024, 768}, '{-1536, 128}, '{2048, -640}};
  // 0.25, -0.5, 1.0, 0.0625
  b_tab = '{256, -512, 1024, 64};
  for (int k = 0; k < `DENSE_NUM_OUTPUTS; k++) begin
    sum = longint'(b_tab[k]);
    for (int i = 0; i < `DENSE_NUM_INPUTS; i++) begin
      xi   = x[i];
      prod = longint'(xi) * longint'(w_tab[k][i]);
      // back to q5.10, rounds toward minus infinity
      sum  = sum + (prod >>> `DENSE_FRAC_BITS);
    end
    // two's complement wrap to the data width
    y[k] = sum[`DENSE_DATA_WIDTH-1:0];
  end
  return y;
endfunction

`endif

//--- dv/tb_dense_stream.sv
// clock, reset, random stream stimulus, model scoreboard and checks
`timescale 1ns/100ps
`include "dense_config.svh"

module tb_dense_stream;

  import dense_pkg::*;

  `include "dense_ref_model.svh"

  // cycles from input transfer to first out_valid
  localparam int LATENCY = `DENSE_NUM_OUTPUTS + 1;
  localparam int ITEMS   = 200;

  logic     clk;
  logic     rst_n;
  logic     in_valid;
  in_vec_t  in_data;
  logic     in_ready;
  logic     out_valid;
  out_vec_t out_data;
  logic     out_ready;

  integer seed;
  string  test_name;

  dense_stream_top dense_stream_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready)
  );

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ################################################
  // failure reporting
  // ################################################

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string what, input logic [63:0] expected,
                                input logic [63:0] actual);
    stop_with_failure($sformatf("[ERROR] %s %s: expected %h, actual %h",
                                test_name, what, expected, actual));
  endtask

  // ################################################
  // stream run with scoreboard
  // ################################################

  // drives on the falling edge and samples 1 ns later
  task automatic run_stream(input string name, input bit random_mode);
    out_vec_t    exp_q[$];
    out_vec_t    exp_v;
    out_vec_t    last_data;
    logic        last_stalled;
    logic        in_taken;
    logic        lat_active;
    logic [31:0] rnd;
    int          sent;
    int          received;
    int          cycles;
    int          lat_count;
    int          gap_left;
    test_name    = name;
    last_data    = '0;
    last_stalled = 1'b0;
    in_taken     = 1'b0;
    lat_active   = 1'b0;
    sent         = 0;
    received     = 0;
    cycles       = 0;
    lat_count    = 0;
    gap_left     = 0;
    while (received < ITEMS) begin
      cycles++;
      if (cycles > ITEMS * 40)
        stop_with_failure($sformatf("timeout in %s: only %0d of %0d outputs arrived",
                                    name, received, ITEMS));
      @(negedge clk);
      // producer holds data until taken and then picks a new item
      if (sent >= ITEMS) begin
        in_valid = 1'b0;
      end else if (!in_valid || in_taken) begin
        in_data  = $random(seed);
        rnd      = $random(seed);
        in_valid = random_mode ? (rnd[1:0] != 2'b00) : 1'b1;
      end
      in_taken  = 1'b0;
      rnd       = $random(seed);
      out_ready = random_mode ? rnd[0] : 1'b1;
      #1;
      // offered output stays put under back-pressure
      if (last_stalled) begin
        assert (out_valid === 1'b1)
          else value_mismatch("held out_valid", 64'(1'b1), 64'(out_valid));
        assert (out_data === last_data)
          else value_mismatch("held out_data", last_data, out_data);
      end
      // no input during the gap after a result
      if (gap_left > 0) begin
        assert (in_ready === 1'b0)
          else value_mismatch("in_ready in gap", 64'(1'b0), 64'(in_ready));
        gap_left--;
      end
      if (lat_active) begin
        lat_count++;
        if (out_valid) begin
          assert (lat_count == LATENCY)
            else value_mismatch("latency", 64'(LATENCY), 64'(lat_count));
          lat_active = 1'b0;
        end
      end
      // output taken on the coming edge
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0)
          stop_with_failure($sformatf("%s: output seen with no input pending", name));
        exp_v = exp_q.pop_front();
        assert (out_data === exp_v)
          else value_mismatch("out_data", exp_v, out_data);
        received++;
        if (!random_mode)
          gap_left = `DENSE_OUTPUT_GAP;
      end
      // input taken on the coming edge
      if (in_valid && in_ready) begin
        exp_q.push_back(ref_layer(in_data));
        sent++;
        in_taken   = 1'b1;
        lat_active = 1'b1;
        lat_count  = 0;
      end
      last_stalled = out_valid && !out_ready;
      last_data    = out_data;
    end
    // a repeated output would show in the quiet tail
    repeat (3 * LATENCY) begin
      @(negedge clk);
      in_valid  = 1'b0;
      out_ready = 1'b1;
      #1;
      assert (out_valid === 1'b0)
        else value_mismatch("extra out_valid", 64'(1'b0), 64'(out_valid));
    end
  endtask

  // ################################################
  // main sequence
  // ################################################

  initial begin
    seed      = 32'hd094_c403;
    test_name = "reset";
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    assert (out_valid === 1'b0)
      else value_mismatch("out_valid", 64'(1'b0), 64'(out_valid));
    // consumer always ready first and then random back-pressure
    run_stream("ready_high", 1'b0);
    run_stream("random_ready", 1'b1);
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- files.f
+incdir+common
+incdir+dv
common/dense_pkg.sv
dense_core/dense_core.sv
stream_wrapper/ap_ctrl_bridge.sv
stream_wrapper/output_holding_buffer.sv
verilog/dense_stream_top.sv
dv/tb_dense_stream.sv

//--- run_sim.sh
#!/bin/sh
# build and run the dense layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module tb_dense_stream \
  -f files.f --Mdir obj_dir -o sim_dense
if [ $? -ne 0 ]; then
  echo "verilator build error"
  exit 1
fi

./obj_dir/sim_dense > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
exit 0

//--- stream_wrapper/ap_ctrl_bridge.sv
// input ready and core start from core history, output-gap wait fsm
`timescale 1ns/100ps
`include "dense_config.svh"

module ap_ctrl_bridge (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  output logic in_ready,
  input  logic out_ready,
  input  logic ap_idle,
  input  logic ap_done,
  input  logic stall,
  output logic ap_start
);

  import dense_pkg::*;

  localparam int GAP_W = $clog2(`DENSE_OUTPUT_GAP + 2);

  logic             idle_prev;
  logic             done_prev;
  logic             out_ready_prev;
  logic             accepting;
  gap_state_t       gap_state;
  logic [GAP_W-1:0] gap_cnt;

  // ################################################
  // previous-cycle core history
  // ################################################

  // idle only counts when no start was taken in that cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idle_prev      <= 1'b0;
      done_prev      <= 1'b0;
      out_ready_prev <= 1'b0;
    end else begin
      idle_prev      <= ap_idle & ~ap_start;
      done_prev      <= ap_done;
      out_ready_prev <= out_ready;
    end
  end

  // core free when it sat idle or its result left last cycle
  assign accepting = idle_prev | (done_prev & out_ready_prev);

  assign in_ready = accepting & ~stall & (gap_state == GAP_OPEN);
  assign ap_start = in_valid & in_ready;

  // ################################################
  // output gap
  // ################################################

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gap_state <= GAP_OPEN;
      gap_cnt   <= '0;
    end else begin
      case (gap_state)
        GAP_OPEN: begin
          if (ap_done && (`DENSE_OUTPUT_GAP != 0)) begin
            gap_state <= GAP_WAIT;
            gap_cnt   <= GAP_W'(`DENSE_OUTPUT_GAP - 1);
          end
        end
        GAP_WAIT: begin
          // last wait cycle reopens
          if (gap_cnt == '0)
            gap_state <= GAP_OPEN;
          else
            gap_cnt <= gap_cnt - 1'b1;
        end
        default: gap_state <= GAP_OPEN;
      endcase
    end
  end

  // no new item in the gap cycles that follow each result
  for (genvar k = 1; k <= `DENSE_OUTPUT_GAP; k++) begin : g_gap_check
    a_no_start_in_gap: assert property (
      @(posedge clk) disable iff (!rst_n) ap_start |-> !$past(ap_done, k)
    );
  end

endmodule

//--- stream_wrapper/output_holding_buffer.sv
// output_holding_buffer: one-entry hold register under back-pressure, output stream
`timescale 1ns/100ps

module output_holding_buffer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ap_done,
  input  dense_pkg::out_vec_t ap_return,
  output logic                out_valid,
  output dense_pkg::out_vec_t out_data,
  input  logic                out_ready,
  output logic                stall
);

  import dense_pkg::*;

  hold_state_t hold_state;
  out_vec_t    held_data;

  // ################################################
  // hold fsm
  // ################################################

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hold_state <= HOLD_EMPTY;
    end else begin
      case (hold_state)
        // result not taken in its done cycle
        HOLD_EMPTY: if (ap_done && !out_ready) hold_state <= HOLD_FULL;
        HOLD_FULL:  if (out_ready) hold_state <= HOLD_EMPTY;
        default:    hold_state <= HOLD_EMPTY;
      endcase
    end
  end

  // capture only on the blocked done cycle
  always_ff @(posedge clk) begin
    if (hold_state == HOLD_EMPTY && ap_done && !out_ready)
      held_data <= ap_return;
  end

  // ################################################
  // output side
  // ################################################

  assign out_valid = ap_done | (hold_state == HOLD_FULL);
  assign out_data  = (hold_state == HOLD_FULL) ? held_data : ap_return;
  assign stall     = out_valid & ~out_ready;

  // stream rule, offered item stays put until taken
  a_hold_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
  );

endmodule

//--- verilog/dense_stream_top.sv
// dense_stream_top: dense core behind a valid/ready stream wrapper
`timescale 1ns/100ps

module dense_stream_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  dense_pkg::in_vec_t  in_data,
  output logic                in_ready,
  output logic                out_valid,
  output dense_pkg::out_vec_t out_data,
  input  logic                out_ready
);

  import dense_pkg::*;

  // core control
  logic     ap_start;
  logic     ap_idle;
  logic     ap_done;
  out_vec_t ap_return;

  // buffer back-pressure into the bridge
  logic stall;

  // ################################################
  // layer
  // ################################################

  // input goes straight to the core
  dense_core dense_core_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .ap_start  (ap_start),
    .ap_idle   (ap_idle),
    .ap_done   (ap_done),
    .ap_in     (in_data),
    .ap_return (ap_return)
  );

  // ################################################
  // stream wrapper
  // ################################################

  ap_ctrl_bridge ap_ctrl_bridge_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_ready (out_ready),
    .ap_idle   (ap_idle),
    .ap_done   (ap_done),
    .stall     (stall),
    .ap_start  (ap_start)
  );

  output_holding_buffer output_holding_buffer_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .ap_done   (ap_done),
    .ap_return (ap_return),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready),
    .stall     (stall)
  );

endmodule
